/* Makefile */
TOP             ?= sweepAcqTb
FILELIST        ?= verilog.f
LOG             ?= sim.log
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary -j 0
PASS_TEXT       := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: TOP FILELIST LOG VERILATOR VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "RESULT: PASS" || (echo "RESULT: FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* include/sweep_consts.svh */
`ifndef SWEEP_CONSTS_SVH
`define SWEEP_CONSTS_SVH

////////////////////
// Stream framing words

// ASCII "SA" marks the start of a sweep
`define SWEEP_HEADER 16'h5341
`define SWEEP_TAIL 16'hFF45
// Upper nibble of each per-step parameter word
`define PARAM_TAG 4'hD

////////////////////
// Acquisition timing and sizes

`define WORDS_PER_FIRE 10
// Cycles to wait after config done falls
`define SC_SETTLE_CYCLES 40
`define FIRE_BUF_DEPTH 32

`endif

/* sim/sweepAcqTb.sv */
`include "sweep_consts.svh"

module sweepAcqTb;
    timeunit 1ns;
    timeprecision 100ps;

    import sweepAcqPkg::*;

    localparam int          ClkPeriod   = 40;
    localparam int          ResetCycles = 10;
    localparam int          DriveSkew   = 5;
    localparam logic [31:0] Seed        = 32'h8180ecd3;

    logic          Clk;
    logic          reset_n;
    logic          SweepStart;
    dacCode_t      StartDAC0;
    dacCode_t      EndDAC0;
    packageCount_t MaxPackageNumber;
    logic          MicrorocConfigDone;
    logic          ParallelData_en;
    acqWord_t      ParallelData;
    dacCode_t      OutDAC0;
    logic          LoadSCParameter;
    logic          SingleACQStart;
    acqWord_t      SweepACQData;
    logic          SweepACQData_en;
    logic          OneDACDone;
    logic          ACQDone;
    logic          Overflow;

    int          errorCount;
    int          checksRun;
    int          watchdogCycles;
    int          cfgDelay;
    int          floodsAsked;
    int          floodsServed;
    int          readIdx;
    logic [31:0] rngState;
    acqWord_t    expectQ[$];

    // One entry per test data line
    int caseStart[$];
    int caseEnd[$];
    int casePkgs[$];
    int caseDelay[$];
    int caseLen[$];

    sweepAcqTop i_sweepAcqTop (
        .Clk                (Clk),
        .reset_n            (reset_n),
        .SweepStart         (SweepStart),
        .StartDAC0          (StartDAC0),
        .EndDAC0            (EndDAC0),
        .MaxPackageNumber   (MaxPackageNumber),
        .MicrorocConfigDone (MicrorocConfigDone),
        .ParallelData_en    (ParallelData_en),
        .ParallelData       (ParallelData),
        .OutDAC0            (OutDAC0),
        .LoadSCParameter    (LoadSCParameter),
        .SingleACQStart     (SingleACQStart),
        .SweepACQData       (SweepACQData),
        .SweepACQData_en    (SweepACQData_en),
        .OneDACDone         (OneDACDone),
        .ACQDone            (ACQDone),
        .Overflow           (Overflow)
    );

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // DAC field goes to the ASIC LSB first
    function automatic dacCode_t mirrorCode(input dacCode_t code);
        dacCode_t mirrored;
        mirrored = {<<{code}};
        return mirrored;
    endfunction

    ////////////////////
    // Compare tasks

    task automatic checkWord(input string name, input acqWord_t got, input acqWord_t exp);
        checksRun++;
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkDac(input string name, input dacCode_t got, input dacCode_t exp);
        checksRun++;
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkCount(input string name, input packageCount_t got,
                              input packageCount_t exp);
        checksRun++;
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    ////////////////////
    // ASIC model

    task automatic writeBurst(input int count, input bit keep);
        for (int i = 0; i < count; i++) begin
            @(posedge Clk);
            #DriveSkew;
            rngState        = xorshift(rngState);
            ParallelData_en = 1'b1;
            ParallelData    = rngState[15:0];
            if (keep) begin
                expectQ.push_back(rngState[15:0]);
            end
        end
        @(posedge Clk);
        #DriveSkew;
        ParallelData_en = 1'b0;
    endtask

    // Config done answers each load pulse and stays high for three cycles
    initial begin
        MicrorocConfigDone = 1'b0;
        forever begin
            @(negedge Clk);
            if (LoadSCParameter) begin
                repeat (cfgDelay) @(posedge Clk);
                #DriveSkew;
                MicrorocConfigDone = 1'b1;
                repeat (3) @(posedge Clk);
                #DriveSkew;
                MicrorocConfigDone = 1'b0;
            end
        end
    end

    initial begin
        int target;
        int gap;
        ParallelData_en = 1'b0;
        ParallelData    = '0;
        rngState        = Seed;
        floodsServed    = 0;
        forever begin
            @(negedge Clk);
            if (floodsServed != floodsAsked) begin
                writeBurst(`FIRE_BUF_DEPTH + 8, 1'b0);
                floodsServed++;
            end else if (SingleACQStart) begin
                target = (MaxPackageNumber == '0) ? 1 : int'(MaxPackageNumber);
                for (int p = 0; p < target; p++) begin
                    // At most two fires in flight keeps the buffer from filling
                    while (expectQ.size() - readIdx > `WORDS_PER_FIRE) @(negedge Clk);
                    rngState = xorshift(rngState);
                    gap      = int'(rngState[2:0]);
                    repeat (gap) @(posedge Clk);
                    writeBurst(`WORDS_PER_FIRE, 1'b1);
                end
                while (SingleACQStart) @(negedge Clk);
            end
        end
    end

    ////////////////////
    // Stream checker

    task automatic runSweep(input int idx);
        int       steps;
        int       target;
        int       nWords;
        int       nParams;
        int       dataLeft;
        int       nextCode;
        int       lastCode;
        int       dacDone;
        int       acqPulses;
        int       cycle;
        int       tailCycle;
        bit       configPending;
        bit       sawDone;
        bit       finished;
        acqWord_t word;
        steps         = caseEnd[idx] - caseStart[idx] + 1;
        target        = (casePkgs[idx] == 0) ? 1 : casePkgs[idx];
        nWords        = 0;
        nParams       = 0;
        dataLeft      = 0;
        nextCode      = caseStart[idx];
        lastCode      = caseStart[idx];
        dacDone       = 0;
        acqPulses     = 0;
        cycle         = 0;
        tailCycle     = 0;
        configPending = 1'b0;
        sawDone       = 1'b0;
        finished      = 1'b0;
        @(posedge Clk);
        #DriveSkew;
        StartDAC0        = dacCode_t'(caseStart[idx]);
        EndDAC0          = dacCode_t'(caseEnd[idx]);
        MaxPackageNumber = packageCount_t'(casePkgs[idx]);
        cfgDelay         = caseDelay[idx];
        @(posedge Clk);
        #DriveSkew;
        SweepStart = 1'b1;
        while (!finished) begin
            @(negedge Clk);
            cycle++;
            if (cycle >= 2 && Overflow) begin
                errorCount++;
                $display("Overflow is set during sweep %0d at %0t", idx, $time);
            end
            if (LoadSCParameter) begin
                checkDac("OutDAC0", OutDAC0, mirrorCode(dacCode_t'(lastCode)));
                configPending = 1'b1;
                sawDone       = 1'b0;
            end
            if (configPending && MicrorocConfigDone) begin
                sawDone = 1'b1;
            end
            if (configPending && sawDone && !MicrorocConfigDone) begin
                configPending = 1'b0;
            end
            if (SingleACQStart && (LoadSCParameter || configPending)) begin
                errorCount++;
                $display("SingleACQStart is high before the load finished at %0t", $time);
            end
            if (OneDACDone) begin
                dacDone++;
            end
            if (SweepACQData_en) begin
                word = SweepACQData;
                if (nWords == 0) begin
                    checkWord("SweepACQData header", word, `SWEEP_HEADER);
                end else if (dataLeft > 0) begin
                    if (readIdx < expectQ.size()) begin
                        checkWord("SweepACQData data", word, expectQ[readIdx]);
                        readIdx++;
                    end else begin
                        errorCount++;
                        $display("Stream carries a data word the ASIC never wrote at %0t", $time);
                    end
                    dataLeft--;
                end else if (nParams < steps) begin
                    checkWord("SweepACQData parameter", word,
                              {`PARAM_TAG, 2'b00, dacCode_t'(nextCode)});
                    lastCode = nextCode;
                    nextCode++;
                    nParams++;
                    dataLeft = target * `WORDS_PER_FIRE;
                end else begin
                    checkWord("SweepACQData tail", word, `SWEEP_TAIL);
                    tailCycle = cycle;
                end
                nWords++;
            end
            if (ACQDone) begin
                acqPulses++;
                finished = 1'b1;
            end
        end
        checkCount("cycles from tail to ACQDone", packageCount_t'(cycle - tailCycle), 1);
        @(posedge Clk);
        #DriveSkew;
        SweepStart = 1'b0;
        // Nothing more may follow ACQDone
        repeat (4) begin
            @(negedge Clk);
            if (ACQDone) begin
                acqPulses++;
            end
            if (SweepACQData_en) begin
                nWords++;
            end
        end
        checkCount("stream length", packageCount_t'(nWords), packageCount_t'(caseLen[idx]));
        checkCount("parameter words", packageCount_t'(nParams), packageCount_t'(steps));
        checkCount("OneDACDone pulses", packageCount_t'(dacDone), packageCount_t'(steps));
        checkCount("ACQDone pulses", packageCount_t'(acqPulses), 1);
        checkCount("words left unread", packageCount_t'(expectQ.size() - readIdx), 0);
    endtask

    task automatic floodCheck();
        @(negedge Clk);
        if (Overflow) begin
            errorCount++;
            $display("Overflow is set before the bus was flooded at %0t", $time);
        end
        floodsAsked++;
        while (floodsServed != floodsAsked) @(negedge Clk);
        @(negedge Clk);
        if (!Overflow) begin
            errorCount++;
            $display("Overflow stayed low after flooding the idle buffer at %0t", $time);
        end
    endtask

    ////////////////////
    // Main sequence

    initial begin
        int    fd;
        int    nFields;
        int    a;
        int    b;
        int    c;
        int    d;
        int    e;
        string line;
        errorCount       = 0;
        checksRun        = 0;
        watchdogCycles   = 0;
        cfgDelay         = 1;
        floodsAsked      = 0;
        readIdx          = 0;
        reset_n          = 1'b0;
        SweepStart       = 1'b0;
        StartDAC0        = '0;
        EndDAC0          = '0;
        MaxPackageNumber = '0;
        fd = $fopen("sim/sweepTestdata.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Cannot open sim/sweepTestdata.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                nFields = $sscanf(line, "%d %d %d %d %d", a, b, c, d, e);
                if (nFields == 5) begin
                    caseStart.push_back(a);
                    caseEnd.push_back(b);
                    casePkgs.push_back(c);
                    caseDelay.push_back(d);
                    caseLen.push_back(e);
                end
            end
            $fclose(fd);
        end
        if (caseStart.size() == 0) begin
            errorCount++;
            $display("No test cases were read");
        end
        // Generous per-word and per-load budget
        watchdogCycles = 2000;
        for (int i = 0; i < caseStart.size(); i++) begin
            watchdogCycles += caseLen[i] * 4 + 100 + (caseEnd[i] - caseStart[i] + 1)
                              * (caseDelay[i] + `SC_SETTLE_CYCLES + 40);
        end
        repeat (ResetCycles) @(posedge Clk);
        #DriveSkew;
        reset_n = 1'b1;
        for (int i = 0; i < caseStart.size(); i++) begin
            runSweep(i);
            if (i == 0) begin
                floodCheck();
            end
        end
        $display("Summary: %0d checks run, %0d errors", checksRun, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge Clk);
        $display("Watchdog expired after %0d cycles, a sweep never finished", watchdogCycles);
        $display("Test failures found");
        $finish;
    end

endmodule

/* sim/sweepTestdata.txt */
# Sweep cases, all decimal, one per line
# startDAC0 endDAC0 maxPackageNumber configDoneDelay expectedStreamLength
100 103 2 7 86
0 0 1 3 13
510 513 0 12 46
1020 1023 3 2 126
37 41 1 20 57
640 641 4 5 84

/* source/fireCaptureBuffer.sv */
`include "sweep_consts.svh"

module fireCaptureBuffer (
    input  logic                  Clk,
    input  logic                  reset_n,
    input  logic                  ParallelData_en,
    input  sweepAcqPkg::acqWord_t ParallelData,
    input  logic                  WordPop,
    input  logic                  FlushBuf,
    output sweepAcqPkg::acqWord_t BufWord,
    output logic                  FireReady,
    output logic                  Overflow
);
    import sweepAcqPkg::*;

    localparam int PtrWidth  = $clog2(`FIRE_BUF_DEPTH);
    localparam int WordWidth = $clog2(`WORDS_PER_FIRE);
    localparam int FireWidth = $clog2(`FIRE_BUF_DEPTH / `WORDS_PER_FIRE + 1);

    acqWord_t             mem [`FIRE_BUF_DEPTH];
    logic [PtrWidth-1:0]  wrPtr;
    logic [PtrWidth-1:0]  rdPtr;
    logic [PtrWidth:0]    fill;
    logic [WordWidth-1:0] wrWordCnt;
    logic [WordWidth-1:0] rdWordCnt;
    logic [FireWidth-1:0] fireCount;
    logic                 full;
    logic                 push;
    logic                 pop;
    logic                 fireIn;
    logic                 fireOut;

    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        return (ptr == PtrWidth'(`FIRE_BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full    = (fill == (PtrWidth + 1)'(`FIRE_BUF_DEPTH));
    assign push    = ParallelData_en && !full && !FlushBuf;
    assign pop     = WordPop && (fill != '0) && !FlushBuf;
    // Tenth word of a fire in, last word of a fire out
    assign fireIn  = push && (wrWordCnt == WordWidth'(`WORDS_PER_FIRE - 1));
    assign fireOut = pop && (rdWordCnt == WordWidth'(`WORDS_PER_FIRE - 1));

    assign FireReady = (fireCount != '0);

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fill      <= '0;
            wrWordCnt <= '0;
            rdWordCnt <= '0;
            fireCount <= '0;
            Overflow  <= 1'b0;
        end else if (FlushBuf) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fill      <= '0;
            wrWordCnt <= '0;
            rdWordCnt <= '0;
            fireCount <= '0;
            Overflow  <= 1'b0;
        end else begin
            if (push) begin
                wrPtr     <= nextPtr(wrPtr);
                wrWordCnt <= fireIn ? '0 : wrWordCnt + 1'b1;
            end
            if (pop) begin
                rdPtr     <= nextPtr(rdPtr);
                rdWordCnt <= fireOut ? '0 : rdWordCnt + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            case ({fireIn, fireOut})
                2'b10:   fireCount <= fireCount + 1'b1;
                2'b01:   fireCount <= fireCount - 1'b1;
                default: fireCount <= fireCount;
            endcase
            // Word dropped on a full buffer
            if (ParallelData_en && full) begin
                Overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (push) begin
            mem[wrPtr] <= ParallelData;
        end
        if (pop) begin
            BufWord <= mem[rdPtr];
        end
    end

endmodule

/* source/scParamLoader.sv */
`include "sweep_consts.svh"

module scParamLoader (
    input  logic                  Clk,
    input  logic                  reset_n,
    input  logic                  LoadReq,
    input  sweepAcqPkg::dacCode_t LoadCode,
    input  logic                  MicrorocConfigDone,
    output logic                  LoadAck,
    output sweepAcqPkg::dacCode_t OutDAC0,
    output logic                  LoadSCParameter
);
    import sweepAcqPkg::*;

    typedef enum logic [2:0] {
        LdIdle,
        LdWaitDone,
        LdWaitFall,
        LdSettle,
        LdAck
    } loadState_t;

    localparam int SettleWidth = $clog2(`SC_SETTLE_CYCLES + 1);

    loadState_t             state;
    logic [SettleWidth-1:0] settleCnt;

    // ASIC shifts the DAC field in LSB first
    function automatic dacCode_t reverseCode(input dacCode_t code);
        dacCode_t reversed;
        for (int i = 0; i < $bits(dacCode_t); i++) begin
            reversed[i] = code[$bits(dacCode_t) - 1 - i];
        end
        return reversed;
    endfunction

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state           <= LdIdle;
            settleCnt       <= '0;
            OutDAC0         <= '0;
            LoadSCParameter <= 1'b0;
            LoadAck         <= 1'b0;
        end else begin
            LoadSCParameter <= 1'b0;
            case (state)
                LdIdle: begin
                    if (LoadReq) begin
                        OutDAC0         <= reverseCode(LoadCode);
                        LoadSCParameter <= 1'b1;
                        state           <= LdWaitDone;
                    end
                end
                LdWaitDone: begin
                    if (MicrorocConfigDone) begin
                        state <= LdWaitFall;
                    end
                end
                // Settling starts once config done drops
                LdWaitFall: begin
                    if (!MicrorocConfigDone) begin
                        settleCnt <= '0;
                        state     <= LdSettle;
                    end
                end
                LdSettle: begin
                    if (settleCnt == SettleWidth'(`SC_SETTLE_CYCLES - 1)) begin
                        LoadAck <= 1'b1;
                        state   <= LdAck;
                    end else begin
                        settleCnt <= settleCnt + 1'b1;
                    end
                end
                LdAck: begin
                    if (!LoadReq) begin
                        LoadAck <= 1'b0;
                        state   <= LdIdle;
                    end
                end
                default: state <= LdIdle;
            endcase
        end
    end

endmodule

/* source/sweepAcqPkg.sv */
package sweepAcqPkg;

    // DAC0 threshold code as seen by the sweep logic
    typedef logic [9:0] dacCode_t;

    // Data and frame words on the ASIC bus and the output stream
    typedef logic [15:0] acqWord_t;

    // Fire packages collected per DAC step
    typedef logic [15:0] packageCount_t;

    // Sweep sequencer states
    typedef enum logic [3:0] {
        Idle,
        SendHeader,
        SendParam,
        LoadReq,
        LoadWaitAck,
        LoadRelease,
        WaitFire,
        ReadWord,
        NextPackage,
        NextDac,
        SendTail,
        Finish
    } seqState_t;

endpackage

/* source/sweepAcqTop.sv */
module sweepAcqTop (
    input  logic                       Clk,
    input  logic                       reset_n,
    input  logic                       SweepStart,
    input  sweepAcqPkg::dacCode_t      StartDAC0,
    input  sweepAcqPkg::dacCode_t      EndDAC0,
    input  sweepAcqPkg::packageCount_t MaxPackageNumber,
    input  logic                       MicrorocConfigDone,
    input  logic                       ParallelData_en,
    input  sweepAcqPkg::acqWord_t      ParallelData,
    output sweepAcqPkg::dacCode_t      OutDAC0,
    output logic                       LoadSCParameter,
    output logic                       SingleACQStart,
    output sweepAcqPkg::acqWord_t      SweepACQData,
    output logic                       SweepACQData_en,
    output logic                       OneDACDone,
    output logic                       ACQDone,
    output logic                       Overflow
);
    import sweepAcqPkg::*;

    // Loader handshake
    logic     LoadReq;
    logic     LoadAck;
    dacCode_t LoadCode;

    // Capture buffer read side
    logic     FireReady;
    logic     WordPop;
    logic     FlushBuf;
    acqWord_t BufWord;

    fireCaptureBuffer i_fireCaptureBuffer (
        .Clk             (Clk),
        .reset_n         (reset_n),
        .ParallelData_en (ParallelData_en),
        .ParallelData    (ParallelData),
        .WordPop         (WordPop),
        .FlushBuf        (FlushBuf),
        .BufWord         (BufWord),
        .FireReady       (FireReady),
        .Overflow        (Overflow)
    );

    scParamLoader i_scParamLoader (
        .Clk                (Clk),
        .reset_n            (reset_n),
        .LoadReq            (LoadReq),
        .LoadCode           (LoadCode),
        .MicrorocConfigDone (MicrorocConfigDone),
        .LoadAck            (LoadAck),
        .OutDAC0            (OutDAC0),
        .LoadSCParameter    (LoadSCParameter)
    );

    sweepSequencer i_sweepSequencer (
        .Clk              (Clk),
        .reset_n          (reset_n),
        .SweepStart       (SweepStart),
        .StartDAC0        (StartDAC0),
        .EndDAC0          (EndDAC0),
        .MaxPackageNumber (MaxPackageNumber),
        .LoadAck          (LoadAck),
        .FireReady        (FireReady),
        .BufWord          (BufWord),
        .LoadReq          (LoadReq),
        .LoadCode         (LoadCode),
        .SingleACQStart   (SingleACQStart),
        .OneDACDone       (OneDACDone),
        .ACQDone          (ACQDone),
        .WordPop          (WordPop),
        .FlushBuf         (FlushBuf),
        .SweepACQData     (SweepACQData),
        .SweepACQData_en  (SweepACQData_en)
    );

endmodule

/* source/sweepSequencer.sv */
`include "sweep_consts.svh"

module sweepSequencer (
    input  logic                       Clk,
    input  logic                       reset_n,
    input  logic                       SweepStart,
    input  sweepAcqPkg::dacCode_t      StartDAC0,
    input  sweepAcqPkg::dacCode_t      EndDAC0,
    input  sweepAcqPkg::packageCount_t MaxPackageNumber,
    input  logic                       LoadAck,
    input  logic                       FireReady,
    input  sweepAcqPkg::acqWord_t      BufWord,
    output logic                       LoadReq,
    output sweepAcqPkg::dacCode_t      LoadCode,
    output logic                       SingleACQStart,
    output logic                       OneDACDone,
    output logic                       ACQDone,
    output logic                       WordPop,
    output logic                       FlushBuf,
    output sweepAcqPkg::acqWord_t      SweepACQData,
    output logic                       SweepACQData_en
);
    import sweepAcqPkg::*;

    localparam int WordWidth = $clog2(`WORDS_PER_FIRE);

    seqState_t            state;
    dacCode_t             dacCode;
    packageCount_t        pkgCount;
    packageCount_t        pkgTarget;
    logic [WordWidth-1:0] wordCnt;
    logic                 startPrev;
    logic                 startEdge;
    logic                 popValid;
    logic                 emitWord;
    acqWord_t             emitData;

    assign startEdge = SweepStart && !startPrev;
    assign FlushBuf  = (state == Idle) && startEdge;
    assign LoadCode  = dacCode;
    // Zero packages still means one per step
    assign pkgTarget = (MaxPackageNumber == '0) ? packageCount_t'(1) : MaxPackageNumber;

    ////////////////////
    // Sweep state machine

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state          <= Idle;
            dacCode        <= '0;
            pkgCount       <= '0;
            wordCnt        <= '0;
            startPrev      <= 1'b0;
            popValid       <= 1'b0;
            LoadReq        <= 1'b0;
            SingleACQStart <= 1'b0;
            OneDACDone     <= 1'b0;
            ACQDone        <= 1'b0;
            WordPop        <= 1'b0;
        end else begin
            startPrev  <= SweepStart;
            popValid   <= WordPop;
            OneDACDone <= 1'b0;
            ACQDone    <= 1'b0;
            case (state)
                Idle: begin
                    if (startEdge) begin
                        dacCode <= StartDAC0;
                        state   <= SendHeader;
                    end
                end
                SendHeader: state <= SendParam;
                SendParam:  state <= sweepAcqPkg::LoadReq;
                // State name is hidden by the handshake port
                sweepAcqPkg::LoadReq: begin
                    LoadReq <= 1'b1;
                    state   <= LoadWaitAck;
                end
                LoadWaitAck: begin
                    if (LoadAck) begin
                        LoadReq <= 1'b0;
                        state   <= LoadRelease;
                    end
                end
                LoadRelease: begin
                    if (!LoadAck) begin
                        SingleACQStart <= 1'b1;
                        pkgCount       <= '0;
                        state          <= WaitFire;
                    end
                end
                WaitFire: begin
                    if (FireReady) begin
                        WordPop <= 1'b1;
                        wordCnt <= '0;
                        state   <= ReadWord;
                    end
                end
                // One pop per cycle for a whole fire
                ReadWord: begin
                    if (wordCnt == WordWidth'(`WORDS_PER_FIRE - 1)) begin
                        WordPop <= 1'b0;
                        state   <= NextPackage;
                    end else begin
                        wordCnt <= wordCnt + 1'b1;
                    end
                end
                NextPackage: begin
                    if (pkgCount + 1'b1 == pkgTarget) begin
                        SingleACQStart <= 1'b0;
                        OneDACDone     <= 1'b1;
                        state          <= NextDac;
                    end else begin
                        pkgCount <= pkgCount + 1'b1;
                        state    <= WaitFire;
                    end
                end
                NextDac: begin
                    if (dacCode < EndDAC0) begin
                        dacCode <= dacCode + 1'b1;
                        state   <= SendParam;
                    end else begin
                        state <= SendTail;
                    end
                end
                SendTail: state <= Finish;
                Finish: begin
                    ACQDone <= 1'b1;
                    state   <= Idle;
                end
                default: state <= Idle;
            endcase
        end
    end

    ////////////////////
    // Output register stage

    always_comb begin
        emitWord = popValid;
        emitData = BufWord;
        case (state)
            SendHeader: begin
                emitWord = 1'b1;
                emitData = `SWEEP_HEADER;
            end
            SendParam: begin
                emitWord = 1'b1;
                emitData = {`PARAM_TAG, 2'b00, dacCode};
            end
            SendTail: begin
                emitWord = 1'b1;
                emitData = `SWEEP_TAIL;
            end
            default: ;
        endcase
    end

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            SweepACQData_en <= 1'b0;
        end else begin
            SweepACQData_en <= emitWord;
        end
    end

    always_ff @(posedge Clk) begin
        if (emitWord) begin
            SweepACQData <= emitData;
        end
    end

endmodule

/* verilog.f */
+incdir+include
source/sweepAcqPkg.sv
source/fireCaptureBuffer.sv
source/scParamLoader.sv
source/sweepSequencer.sv
source/sweepAcqTop.sv
sim/sweepAcqTb.sv
